// File: iu_cfg.svh
// Configuration macros for the integer execution unit
//   data word width
//   physical register tag width
//   divider iteration count

`ifndef IU_CFG_SVH
`define IU_CFG_SVH

// Data path width
`define IU_XLEN 32

// Destination tag width
`define IU_PREG_W 6

// One quotient bit per iteration
`define IU_DIV_CYCLES `IU_XLEN

`endif

// File: iu_op_pkg.sv
// Operation encodings of the execution unit
//   iu_op_t    issued operation
//   iu_unit_t  functional unit selection
//   op_unit    operation to unit decode

package iu_op_pkg;

  typedef enum logic [4:0] {
    op_add   = 5'h00,
    op_sub   = 5'h01,
    op_and   = 5'h02,
    op_or    = 5'h03,
    op_xor   = 5'h04,
    op_sll   = 5'h05,
    op_srl   = 5'h06,
    op_sra   = 5'h07,
    op_slt   = 5'h08,
    op_sltu  = 5'h09,
    op_mul   = 5'h10,
    op_mulh  = 5'h11,
    op_mulhu = 5'h12,
    op_div   = 5'h18,
    op_divu  = 5'h19,
    op_rem   = 5'h1a,
    op_remu  = 5'h1b
  } iu_op_t;

  typedef enum logic [1:0] {
    unit_alu = 2'd0,
    unit_mul = 2'd1,
    unit_div = 2'd2
  } iu_unit_t;

  function automatic iu_unit_t op_unit(input iu_op_t op);
    case (op)
      op_mul, op_mulh, op_mulhu:        return unit_mul;
      op_div, op_divu, op_rem, op_remu: return unit_div;
      default:                          return unit_alu;
    endcase
  endfunction

endpackage

// File: iu_data_pkg.sv
// Data types of the execution unit
//   iu_word_t   one data word
//   iu_dword_t  full multiplier product
//   iu_preg_t   destination physical register tag

`include "iu_cfg.svh"

package iu_data_pkg;

  typedef logic [`IU_XLEN-1:0]   iu_word_t;

  typedef logic [2*`IU_XLEN-1:0] iu_dword_t;

  typedef logic [`IU_PREG_W-1:0] iu_preg_t;

endpackage

// File: pa_iu_alu.sv
// Single cycle arithmetic and logic unit
//   add, sub, and, or, xor
//   shifts by the low five bits of src1
//   signed and unsigned set-less-than

`timescale 1ns/10ps

module pa_iu_alu import iu_op_pkg::*, iu_data_pkg::*; (
  input  iu_op_t   alu_op,
  input  iu_word_t alu_src0,
  input  iu_word_t alu_src1,
  output iu_word_t alu_rslt
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Upper bits of the shift amount are ignored
  assign shamt = alu_src1[4:0];

  assign lt_signed   = $signed(alu_src0) < $signed(alu_src1);
  assign lt_unsigned = alu_src0 < alu_src1;

  always_comb begin
    case (alu_op)
      op_add: begin
        alu_rslt = alu_src0 + alu_src1;
      end
      op_sub: begin
        alu_rslt = alu_src0 - alu_src1;
      end
      op_and: begin
        alu_rslt = alu_src0 & alu_src1;
      end
      op_or: begin
        alu_rslt = alu_src0 | alu_src1;
      end
      op_xor: begin
        alu_rslt = alu_src0 ^ alu_src1;
      end
      op_sll: begin
        alu_rslt = alu_src0 << shamt;
      end
      op_srl: begin
        alu_rslt = alu_src0 >> shamt;
      end
      op_sra: begin
        alu_rslt = iu_word_t'($signed(alu_src0) >>> shamt);
      end
      op_slt: begin
        alu_rslt = iu_word_t'(lt_signed);
      end
      op_sltu: begin
        alu_rslt = iu_word_t'(lt_unsigned);
      end
      // Multiply and divide ops never select this result
      default: begin
        alu_rslt = '0;
      end
    endcase
  end

endmodule

// File: pa_iu_mul.sv
// Two stage pipelined multiplier
//   stage one extends the operands and forms the full product
//   stage two selects the low or high word
//   stage two holds while stalled by the controller

`timescale 1ns/10ps

`include "iu_cfg.svh"

module pa_iu_mul import iu_op_pkg::*, iu_data_pkg::*; (
  input  logic     forever_cpuclk,
  input  logic     reset,
  input  logic     mul_go,
  input  iu_op_t   mul_op,
  input  iu_word_t mul_src0,
  input  iu_word_t mul_src1,
  input  iu_preg_t mul_dst_preg,
  input  logic     mul_ex2_stall,
  output logic     mul_ex2_vld,
  output iu_preg_t mul_ex2_preg,
  output iu_word_t mul_ex2_rslt
);

  localparam int FULL_W = 2*`IU_XLEN + 2;

  logic                          ex1_signed;
  logic                          ex1_high;
  logic signed [`IU_XLEN:0]      ex1_a;
  logic signed [`IU_XLEN:0]      ex1_b;
  logic signed [FULL_W-1:0]      ex1_full;
  iu_dword_t                     ex1_prod;
  iu_dword_t                     ex2_prod;
  logic                          ex2_high;

  // Only mulh treats both operands as signed
  assign ex1_signed = (mul_op == op_mulh);
  assign ex1_high   = (mul_op == op_mulh) || (mul_op == op_mulhu);

  assign ex1_a    = {ex1_signed & mul_src0[`IU_XLEN-1], mul_src0};
  assign ex1_b    = {ex1_signed & mul_src1[`IU_XLEN-1], mul_src1};
  assign ex1_full = FULL_W'(ex1_a) * FULL_W'(ex1_b);
  assign ex1_prod = ex1_full[2*`IU_XLEN-1:0];

  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      mul_ex2_vld <= 1'b0;
    end else if (!mul_ex2_stall) begin
      mul_ex2_vld <= mul_go;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (mul_go && !mul_ex2_stall) begin
      ex2_prod     <= ex1_prod;
      ex2_high     <= ex1_high;
      mul_ex2_preg <= mul_dst_preg;
    end
  end

  assign mul_ex2_rslt = ex2_high ? ex2_prod[2*`IU_XLEN-1:`IU_XLEN] : ex2_prod[`IU_XLEN-1:0];

endmodule

// File: pa_iu_div.sv
// Iterative divider, one quotient bit per cycle
//   signed and unsigned divide and remainder
//   restoring shift-subtract on absolute values
//   result held until granted by the controller

`timescale 1ns/10ps

`include "iu_cfg.svh"

module pa_iu_div import iu_op_pkg::*, iu_data_pkg::*; (
  input  logic     forever_cpuclk,
  input  logic     reset,
  input  logic     div_go,
  input  iu_op_t   div_op,
  input  iu_word_t div_src0,
  input  iu_word_t div_src1,
  input  iu_preg_t div_dst_preg,
  input  logic     div_grant,
  output logic     div_busy,
  output logic     div_rslt_vld,
  output iu_word_t div_rslt,
  output iu_preg_t div_preg
);

  localparam int CNT_W = $clog2(`IU_DIV_CYCLES + 1);

  logic             src_signed;
  logic             sign0;
  logic             sign1;
  logic             dvs_zero;
  iu_word_t         abs0;
  iu_word_t         abs1;
  logic [CNT_W-1:0] cnt;
  logic             itering;
  logic             finish;
  iu_word_t         quot_r;
  iu_word_t         rem_r;
  iu_word_t         dvs_r;
  logic             neg_q;
  logic             neg_r;
  logic             is_rem;
  logic [`IU_XLEN:0] trial;
  logic [`IU_XLEN:0] diff;
  iu_word_t         quot_fix;
  iu_word_t         rem_fix;

  assign src_signed = (div_op == op_div) || (div_op == op_rem);
  assign sign0      = src_signed & div_src0[`IU_XLEN-1];
  assign sign1      = src_signed & div_src1[`IU_XLEN-1];
  assign dvs_zero   = (div_src1 == '0);
  assign abs0       = sign0 ? -div_src0 : div_src0;
  assign abs1       = sign1 ? -div_src1 : div_src1;

  assign itering = div_busy && (cnt != '0);
  assign finish  = div_busy && (cnt == '0) && !div_rslt_vld;

  // Shift in the next dividend bit and try the subtract
  assign trial = {rem_r, quot_r[`IU_XLEN-1]};
  assign diff  = trial - {1'b0, dvs_r};

  assign quot_fix = neg_q ? -quot_r : quot_r;
  assign rem_fix  = neg_r ? -rem_r : rem_r;

  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      div_busy     <= 1'b0;
      div_rslt_vld <= 1'b0;
      cnt          <= '0;
    end else if (div_go) begin
      div_busy <= 1'b1;
      cnt      <= CNT_W'(`IU_DIV_CYCLES);
    end else if (itering) begin
      cnt <= cnt - CNT_W'(1);
    end else if (finish) begin
      div_rslt_vld <= 1'b1;
    end else if (div_grant) begin
      div_busy     <= 1'b0;
      div_rslt_vld <= 1'b0;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (div_go) begin
      quot_r   <= abs0;
      rem_r    <= '0;
      dvs_r    <= abs1;
      // Zero divisor keeps an all ones quotient
      neg_q    <= (sign0 ^ sign1) && !dvs_zero;
      neg_r    <= sign0;
      is_rem   <= (div_op == op_rem) || (div_op == op_remu);
      div_preg <= div_dst_preg;
    end else if (itering) begin
      if (!diff[`IU_XLEN]) begin
        rem_r  <= diff[`IU_XLEN-1:0];
        quot_r <= {quot_r[`IU_XLEN-2:0], 1'b1};
      end else begin
        rem_r  <= trial[`IU_XLEN-1:0];
        quot_r <= {quot_r[`IU_XLEN-2:0], 1'b0};
      end
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (finish) begin
      div_rslt <= is_rem ? rem_fix : quot_fix;
    end
  end

endmodule

// File: pa_iu_ctrl.sv
// Execution unit controller
//   issue steering to ALU, multiplier and divider
//   issue ready generation
//   write-back arbitration and write-back register

`timescale 1ns/10ps

module pa_iu_ctrl import iu_op_pkg::*, iu_data_pkg::*; (
  input  logic     forever_cpuclk,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  iu_op_t   in_op,
  input  iu_preg_t in_dst_preg,
  output logic     alu_go,
  output logic     mul_go,
  output logic     div_go,
  output logic     mul_ex2_stall,
  output logic     div_grant,
  input  iu_word_t alu_rslt,
  input  logic     mul_ex2_vld,
  input  iu_preg_t mul_ex2_preg,
  input  iu_word_t mul_ex2_rslt,
  input  logic     div_busy,
  input  logic     div_rslt_vld,
  input  iu_preg_t div_preg,
  input  iu_word_t div_rslt,
  output logic     wb_valid,
  input  logic     wb_ready,
  output iu_preg_t wb_preg,
  output iu_word_t wb_data
);

  iu_unit_t in_unit;
  logic     wb_free;
  logic     mul_take;
  logic     accept;

  assign in_unit = op_unit(in_op);

  // Write-back register empty or drained this cycle
  assign wb_free = !wb_valid || wb_ready;

  // Divider result first, then multiplier stage two
  assign div_grant     = wb_free && div_rslt_vld;
  assign mul_take      = wb_free && mul_ex2_vld && !div_rslt_vld;
  assign mul_ex2_stall = mul_ex2_vld && !mul_take;

  always_comb begin
    in_ready = wb_free;
    if ((in_unit == unit_div) && div_busy) begin
      in_ready = 1'b0;
    end
    if ((in_unit == unit_alu) && (mul_ex2_vld || div_rslt_vld)) begin
      in_ready = 1'b0;
    end
    // Stage two of the multiplier must move before a new multiply enters
    if ((in_unit == unit_mul) && mul_ex2_stall) begin
      in_ready = 1'b0;
    end
  end

  assign accept = in_valid && in_ready;
  assign alu_go = accept && (in_unit == unit_alu);
  assign mul_go = accept && (in_unit == unit_mul);
  assign div_go = accept && (in_unit == unit_div);

  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else if (wb_free) begin
      wb_valid <= div_grant || mul_take || alu_go;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (div_grant) begin
      wb_preg <= div_preg;
      wb_data <= div_rslt;
    end else if (mul_take) begin
      wb_preg <= mul_ex2_preg;
      wb_data <= mul_ex2_rslt;
    end else if (alu_go) begin
      wb_preg <= in_dst_preg;
      wb_data <= alu_rslt;
    end
  end

endmodule

// File: pa_iu_top.sv
// Integer execution unit top level
//   controller, ALU, multiplier and divider
//   one issue port and one write-back port

`timescale 1ns/10ps

module pa_iu_top import iu_op_pkg::*, iu_data_pkg::*; (
  input  logic     forever_cpuclk,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  iu_op_t   in_op,
  input  iu_word_t in_src0,
  input  iu_word_t in_src1,
  input  iu_preg_t in_dst_preg,
  output logic     wb_valid,
  input  logic     wb_ready,
  output iu_preg_t wb_preg,
  output iu_word_t wb_data
);

  iu_word_t alu_rslt;
  logic     mul_go;
  logic     mul_ex2_stall;
  logic     mul_ex2_vld;
  iu_preg_t mul_ex2_preg;
  iu_word_t mul_ex2_rslt;
  logic     div_go;
  logic     div_grant;
  logic     div_busy;
  logic     div_rslt_vld;
  iu_word_t div_rslt;
  iu_preg_t div_preg;

  // ALU is purely combinational and needs no start pulse
  pa_iu_ctrl x_pa_iu_ctrl (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .in_op          (in_op),
    .in_dst_preg    (in_dst_preg),
    .alu_go         (),
    .mul_go         (mul_go),
    .div_go         (div_go),
    .mul_ex2_stall  (mul_ex2_stall),
    .div_grant      (div_grant),
    .alu_rslt       (alu_rslt),
    .mul_ex2_vld    (mul_ex2_vld),
    .mul_ex2_preg   (mul_ex2_preg),
    .mul_ex2_rslt   (mul_ex2_rslt),
    .div_busy       (div_busy),
    .div_rslt_vld   (div_rslt_vld),
    .div_preg       (div_preg),
    .div_rslt       (div_rslt),
    .wb_valid       (wb_valid),
    .wb_ready       (wb_ready),
    .wb_preg        (wb_preg),
    .wb_data        (wb_data)
  );

  pa_iu_alu x_pa_iu_alu (
    .alu_op   (in_op),
    .alu_src0 (in_src0),
    .alu_src1 (in_src1),
    .alu_rslt (alu_rslt)
  );

  pa_iu_mul x_pa_iu_mul (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .mul_go         (mul_go),
    .mul_op         (in_op),
    .mul_src0       (in_src0),
    .mul_src1       (in_src1),
    .mul_dst_preg   (in_dst_preg),
    .mul_ex2_stall  (mul_ex2_stall),
    .mul_ex2_vld    (mul_ex2_vld),
    .mul_ex2_preg   (mul_ex2_preg),
    .mul_ex2_rslt   (mul_ex2_rslt)
  );

  pa_iu_div x_pa_iu_div (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .div_go         (div_go),
    .div_op         (in_op),
    .div_src0       (in_src0),
    .div_src1       (in_src1),
    .div_dst_preg   (in_dst_preg),
    .div_grant      (div_grant),
    .div_busy       (div_busy),
    .div_rslt_vld   (div_rslt_vld),
    .div_rslt       (div_rslt),
    .div_preg       (div_preg)
  );

endmodule

// File: tb_clk_gen.sv
// Testbench clock and reset generator
//   4 ns clock period
//   reset held high for the first two rising edges

`timescale 1ns/10ps

module tb_clk_gen (
  output logic forever_cpuclk,
  output logic reset
);

  initial begin
    forever_cpuclk = 1'b0;
    forever #2 forever_cpuclk = ~forever_cpuclk;
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge forever_cpuclk);
    reset <= 1'b0;
  end

endmodule

// File: tb_pa_iu_top.sv
// Testbench for the integer execution unit
//   table of operations with hand-derived expected results
//   issue driver, write-back monitor and tag scoreboard
//   random back-pressure on the write-back port

`timescale 1ns/10ps

`include "iu_cfg.svh"

module tb_pa_iu_top import iu_op_pkg::*, iu_data_pkg::*; ();

  localparam int TAGS        = 1 << `IU_PREG_W;
  localparam int WAIT_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 2000;

  logic     forever_cpuclk;
  logic     reset;
  logic     in_valid;
  logic     in_ready;
  iu_op_t   in_op;
  iu_word_t in_src0;
  iu_word_t in_src1;
  iu_preg_t in_dst_preg;
  logic     wb_valid;
  logic     wb_ready = 1'b1;
  iu_preg_t wb_preg;
  iu_word_t wb_data;

  iu_op_t   tbl_op   [TAGS];
  iu_word_t tbl_src0 [TAGS];
  iu_word_t tbl_src1 [TAGS];
  iu_preg_t tbl_tag  [TAGS];
  iu_word_t tbl_exp  [TAGS];
  int       n_entries = 0;
  int       div_entry = 0;

  // Scoreboard indexed by tag
  iu_word_t sb_exp   [TAGS];
  bit       issued   [TAGS];
  bit       written  [TAGS];
  int       wb_order [TAGS];

  integer   seed = 6;
  bit       random_ready = 1'b0;
  bit       timed_out = 1'b0;
  int       seq_errors = 0;
  int       value_errors = 0;
  int       other_errors = 0;
  int       done_count = 0;
  bit       hold_prev = 1'b0;
  iu_preg_t prev_preg;
  iu_word_t prev_data;

  tb_clk_gen x_clk_gen (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset)
  );

  pa_iu_top uut (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .in_op          (in_op),
    .in_src0        (in_src0),
    .in_src1        (in_src1),
    .in_dst_preg    (in_dst_preg),
    .wb_valid       (wb_valid),
    .wb_ready       (wb_ready),
    .wb_preg        (wb_preg),
    .wb_data        (wb_data)
  );

  function automatic int compare_word(input string name, input iu_word_t got,
                                      input iu_word_t exp);
    if (got !== exp) begin
      $display("Error: %s = %h, expected %h", name, got, exp);
      return 1;
    end
    return 0;
  endfunction

  function automatic int compare_preg(input string name, input iu_preg_t got,
                                      input iu_preg_t exp);
    if (got !== exp) begin
      $display("Error: %s = %h, expected %h", name, got, exp);
      return 1;
    end
    return 0;
  endfunction

  function automatic int compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s = %h, expected %h", name, got, exp);
      return 1;
    end
    return 0;
  endfunction

  task automatic add_entry(input iu_op_t op, input iu_word_t src0, input iu_word_t src1,
                           input iu_word_t exp);
    tbl_op[n_entries]   = op;
    tbl_src0[n_entries] = src0;
    tbl_src1[n_entries] = src1;
    tbl_tag[n_entries]  = iu_preg_t'(n_entries);
    tbl_exp[n_entries]  = exp;
    n_entries++;
  endtask

  // Called just after a rising edge, returns just after the accepting edge
  task automatic issue_entry(input int idx);
    int waited;
    waited = 0;
    if (!timed_out) begin
      in_valid    <= 1'b1;
      in_op       <= tbl_op[idx];
      in_src0     <= tbl_src0[idx];
      in_src1     <= tbl_src1[idx];
      in_dst_preg <= tbl_tag[idx];
      sb_exp[tbl_tag[idx]] = tbl_exp[idx];
      @(negedge forever_cpuclk);
      while (!in_ready && waited < WAIT_LIMIT) begin
        waited++;
        @(negedge forever_cpuclk);
      end
      if (!in_ready) begin
        $display("Timeout waiting for the DUT to accept table entry %0d", idx);
        timed_out = 1'b1;
      end else begin
        issued[tbl_tag[idx]] = 1'b1;
        @(posedge forever_cpuclk);
      end
    end
  endtask

  always @(posedge forever_cpuclk) begin
    if (random_ready) begin
      wb_ready <= ($random(seed) % 2) != 0;
    end else begin
      wb_ready <= 1'b1;
    end
  end

  // Write-back monitor samples at the falling edge
  always @(negedge forever_cpuclk) begin
    if (!reset) begin
      if (hold_prev) begin
        if (!wb_valid) begin
          $display("wb_valid dropped while the result was stalled");
          other_errors++;
        end
        value_errors += compare_preg("wb_preg", wb_preg, prev_preg);
        value_errors += compare_word("wb_data", wb_data, prev_data);
      end
      if (wb_valid && wb_ready) begin
        if (!issued[wb_preg] || written[wb_preg]) begin
          $display("Result under tag %h was never issued or was already written back",
                   wb_preg);
          other_errors++;
        end else begin
          value_errors += compare_word("wb_data", wb_data, sb_exp[wb_preg]);
          written[wb_preg] = 1'b1;
          wb_order[wb_preg] = done_count;
          done_count++;
        end
      end
      hold_prev = wb_valid && !wb_ready;
      prev_preg = wb_preg;
      prev_data = wb_data;
    end
  end

  initial begin
    int waited;
    in_valid    = 1'b0;
    in_op       = op_add;
    in_src0     = '0;
    in_src1     = '0;
    in_dst_preg = '0;

    // op, src0, src1, expected result
    add_entry(op_add,   32'h0000_0005, 32'h0000_0007, 32'h0000_000c);
    add_entry(op_mul,   32'h0000_0006, 32'h0000_0007, 32'h0000_002a);
    add_entry(op_add,   32'hffff_ffff, 32'h0000_0001, 32'h0000_0000);
    add_entry(op_sub,   32'h0000_0003, 32'h0000_0005, 32'hffff_fffe);
    add_entry(op_and,   32'hf0f0_f0f0, 32'h0ff0_0ff0, 32'h00f0_00f0);
    add_entry(op_or,    32'hf0f0_f0f0, 32'h0ff0_0ff0, 32'hfff0_fff0);
    add_entry(op_xor,   32'hf0f0_f0f0, 32'h0ff0_0ff0, 32'hff00_ff00);
    add_entry(op_sll,   32'h0000_0001, 32'h0000_0024, 32'h0000_0010);
    add_entry(op_srl,   32'h8000_0000, 32'h0000_003f, 32'h0000_0001);
    add_entry(op_sra,   32'h8000_0000, 32'h0000_0024, 32'hf800_0000);
    add_entry(op_sll,   32'h1234_5678, 32'h0000_0020, 32'h1234_5678);
    add_entry(op_slt,   32'hffff_ffff, 32'h0000_0001, 32'h0000_0001);
    add_entry(op_sltu,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0000);
    add_entry(op_sltu,  32'h0000_0001, 32'hffff_ffff, 32'h0000_0001);
    add_entry(op_mul,   32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001);
    add_entry(op_mulh,  32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000);
    add_entry(op_mulhu, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe);
    add_entry(op_mulh,  32'h8000_0000, 32'h0000_0002, 32'hffff_ffff);
    add_entry(op_mulhu, 32'h8000_0000, 32'h0000_0002, 32'h0000_0001);
    add_entry(op_mulh,  32'h7fff_ffff, 32'h7fff_ffff, 32'h3fff_ffff);
    add_entry(op_mul,   32'h1234_5678, 32'h0000_0010, 32'h2345_6780);
    // Multiply and ALU ops behind a running divide
    div_entry = n_entries;
    add_entry(op_div,   32'hffff_ff9c, 32'h0000_0007, 32'hffff_fff2);
    add_entry(op_mul,   32'h0000_0003, 32'h0000_0005, 32'h0000_000f);
    add_entry(op_add,   32'h0000_0010, 32'h0000_0020, 32'h0000_0030);
    add_entry(op_xor,   32'haaaa_aaaa, 32'h5555_5555, 32'hffff_ffff);
    add_entry(op_rem,   32'hffff_ff9c, 32'h0000_0007, 32'hffff_fffe);
    add_entry(op_sub,   32'h0000_0000, 32'h0000_0001, 32'hffff_ffff);
    add_entry(op_divu,  32'h0000_0064, 32'h0000_0007, 32'h0000_000e);
    add_entry(op_remu,  32'h0000_0064, 32'h0000_0007, 32'h0000_0002);
    add_entry(op_div,   32'h0000_0064, 32'h0000_0000, 32'hffff_ffff);
    add_entry(op_rem,   32'h0000_0064, 32'h0000_0000, 32'h0000_0064);
    add_entry(op_remu,  32'hffff_ff9c, 32'h0000_0000, 32'hffff_ff9c);
    add_entry(op_div,   32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
    add_entry(op_rem,   32'h8000_0000, 32'hffff_ffff, 32'h0000_0000);
    add_entry(op_div,   32'h0000_0064, 32'hffff_fff9, 32'hffff_fff2);
    add_entry(op_rem,   32'hffff_ff9c, 32'hffff_fff9, 32'hffff_fffe);
    add_entry(op_mulhu, 32'h0000_0002, 32'h0000_0003, 32'h0000_0000);
    add_entry(op_and,   32'h1234_5678, 32'hffff_0000, 32'h1234_0000);

    waited = 0;
    @(negedge forever_cpuclk);
    while (reset && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge forever_cpuclk);
    end
    if (reset) begin
      $display("Timeout waiting for reset to be released");
      timed_out = 1'b1;
    end

    // Latency with wb_ready held high and nothing pending
    if (!timed_out) begin
      seq_errors += compare_bit("wb_valid", wb_valid, 1'b0);
      seq_errors += compare_bit("in_ready", in_ready, 1'b1);
      @(posedge forever_cpuclk);
      issue_entry(0);
      in_valid <= 1'b0;
      @(negedge forever_cpuclk);
      seq_errors += compare_bit("wb_valid", wb_valid, 1'b1);
      seq_errors += compare_preg("wb_preg", wb_preg, tbl_tag[0]);
      @(posedge forever_cpuclk);
      issue_entry(1);
      in_valid <= 1'b0;
      @(negedge forever_cpuclk);
      seq_errors += compare_bit("wb_valid", wb_valid, 1'b0);
      @(negedge forever_cpuclk);
      seq_errors += compare_bit("wb_valid", wb_valid, 1'b1);
      seq_errors += compare_preg("wb_preg", wb_preg, tbl_tag[1]);
    end

    random_ready = 1'b1;
    @(posedge forever_cpuclk);
    for (int i = 2; i < n_entries; i++) begin
      issue_entry(i);
    end
    in_valid <= 1'b0;

    waited = 0;
    while (!timed_out && done_count < n_entries && waited < DRAIN_LIMIT) begin
      waited++;
      @(negedge forever_cpuclk);
    end
    if (!timed_out && done_count < n_entries) begin
      $display("Timeout waiting for all results to be written back");
      timed_out = 1'b1;
    end
    for (int i = 0; i < n_entries; i++) begin
      if (!written[tbl_tag[i]]) begin
        $display("Table entry %0d under tag %h was never written back", i, tbl_tag[i]);
        seq_errors++;
      end
    end
    // Ops issued behind the divide overtake it
    for (int i = div_entry + 1; i <= div_entry + 3; i++) begin
      if (wb_order[tbl_tag[i]] > wb_order[tbl_tag[div_entry]]) begin
        $display("Table entry %0d finished after the divide issued before it", i);
        seq_errors++;
      end
    end
    if (!timed_out) begin
      @(negedge forever_cpuclk);
      seq_errors += compare_bit("wb_valid", wb_valid, 1'b0);
    end

    $display("Error counts: value %0d, sequence %0d, protocol %0d, timeout %0d",
             value_errors, seq_errors, other_errors, timed_out);
    if (value_errors == 0 && seq_errors == 0 && other_errors == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+.
iu_op_pkg.sv
iu_data_pkg.sv
pa_iu_alu.sv
pa_iu_mul.sv
pa_iu_div.sv
pa_iu_ctrl.sv
pa_iu_top.sv
tb_clk_gen.sv
tb_pa_iu_top.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 -f verilog.f --top-module tb_pa_iu_top
	./obj_dir/Vtb_pa_iu_top | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
